//--- verilog/cache_pkg.sv
package cache_pkg;

    // Bus and word widths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // Direct mapped line geometry of 16 sets with 4 words each
    localparam int words_per_line = 4;
    localparam int offset_w = 2;     // Word in line
    localparam int index_w = 4;      // Set select
    localparam int byte_off_w = 2;   // Byte in word
    localparam int num_sets = 2 ** index_w;

    // Address field positions
    localparam int offset_lsb = byte_off_w;
    localparam int index_lsb = offset_lsb + offset_w;
    localparam int tag_lsb = index_lsb + index_w;

    localparam int tag_w = addr_w - tag_lsb;          // 24
    localparam int line_addr_w = tag_w + index_w;     // 28

    // Position of the final beat of a refill
    localparam logic [offset_w-1:0] last_word = offset_w'(words_per_line - 1);

    // Controller FSM
    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_lookup,        // First APB access cycle, tag compare
        ctrl_refill_wait,   // Line fetch in progress
        ctrl_respond        // Tag written, answer the read
    } ctrl_state_t;

endpackage

//--- verilog/axi_pkg.sv
package axi_pkg;

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } axi_burst_t;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_t;

    // Fixed AR fields for a one-line refill
    localparam int axi_id_w = 1;
    localparam logic [7:0] ar_len = 8'd3;     // Four beats
    localparam logic [2:0] ar_size = 3'd2;    // Four bytes per beat
    localparam logic [3:0] ar_cache = 4'b0011;
    localparam logic [axi_id_w-1:0] ar_id = '0;

    // Refill sequencer FSM
    typedef enum logic [1:0] {
        rf_idle,
        rf_addr_phase,
        rf_data_phase,
        rf_end_phase
    } refill_state_t;

endpackage

//--- verilog/refill_if.sv
`timescale 1ns/100ps

interface refill_if;
    import cache_pkg::*;

    // Request from the controller
    logic                   replace_valid;
    logic [line_addr_w-1:0] replace_addr;

    // High while a line fetch is running
    logic                   replace;

    // Beat stream towards the word banks
    logic                   read_valid;
    logic [offset_w-1:0]    read_addr;
    logic [data_w-1:0]      read_rdata;

    modport ctrl (
        output replace_valid,
        output replace_addr,
        input  replace
    );

    modport refill (
        input  replace_valid,
        input  replace_addr,
        output replace,
        output read_valid,
        output read_addr,
        output read_rdata
    );

    // Banks only use the index bits of replace_addr
    modport bank (
        input read_valid,
        input read_addr,
        input read_rdata,
        input replace_addr
    );

endinterface

//--- verilog/line_refill_axi.sv
`timescale 1ns/100ps

module line_refill_axi (
    input  logic                            clk,
    input  logic                            reset,

    // AXI read address channel
    output logic                            arvalid,
    input  logic                            arready,
    output logic [cache_pkg::addr_w-1:0]    araddr,
    output logic [7:0]                      arlen,
    output logic [2:0]                      arsize,
    output logic [1:0]                      arburst,
    output logic [3:0]                      arcache,
    output logic [axi_pkg::axi_id_w-1:0]    arid,

    // AXI read data channel
    input  logic                            rvalid,
    output logic                            rready,
    input  logic [cache_pkg::data_w-1:0]    rdata,
    input  logic [1:0]                      rresp,
    input  logic                            rlast,

    refill_if.refill                        rif
);
    import cache_pkg::*;
    import axi_pkg::*;

    refill_state_t state;
    logic          slave_error;   // Some beat of this burst came back bad
    logic          beat;

    // Constant burst shape
    assign arlen   = ar_len;
    assign arsize  = ar_size;
    assign arburst = burst_incr;
    assign arcache = ar_cache;
    assign arid    = ar_id;

    // Line aligned start address
    assign araddr = {rif.replace_addr, {(offset_w + byte_off_w){1'b0}}};

    assign beat = rvalid && rready;

    assign rif.read_valid = beat;
    assign rif.read_rdata = rdata;   // Beats go straight to the banks

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= rf_idle;
            slave_error   <= 1'b0;
            rif.read_addr <= '0;
        end else begin
            case (state)
                rf_idle: begin
                    rif.read_addr <= '0;
                    if (rif.replace_valid)
                        state <= rf_addr_phase;
                end
                rf_addr_phase: begin
                    // Also the restart point after a failed burst
                    slave_error   <= 1'b0;
                    rif.read_addr <= '0;
                    if (arready)
                        state <= rf_data_phase;
                end
                rf_data_phase: begin
                    if (beat) begin
                        // A burst cannot be cut short, so remember the error
                        if (rresp != resp_okay)
                            slave_error <= 1'b1;
                        if (rlast)
                            state <= rf_end_phase;
                        else
                            rif.read_addr <= rif.read_addr + 1'b1;
                    end
                end
                default: begin
                    state <= slave_error ? rf_addr_phase : rf_idle;
                end
            endcase
        end
    end

    assign rif.replace = (state != rf_idle);
    assign arvalid     = (state == rf_addr_phase);
    assign rready      = (state == rf_data_phase);

    // Memory must end the burst exactly on the fourth beat
    a_rlast_on_last_beat: assert property (
        @(posedge clk) disable iff (reset)
        beat |-> (rlast == (rif.read_addr == last_word))
    );

    // Controller keeps the line address steady through the handshake
    a_araddr_stable: assert property (
        @(posedge clk) disable iff (reset)
        arvalid && !arready |=> $stable(araddr)
    );

endmodule

//--- verilog/line_word_bank.sv
`timescale 1ns/100ps

module line_word_bank #(
    parameter logic [cache_pkg::offset_w-1:0] bank_pos = '0
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cache_pkg::index_w-1:0]   bank_index,
    output logic [cache_pkg::data_w-1:0]    rdata,
    refill_if.bank                          rif
);
    import cache_pkg::*;

    logic [data_w-1:0]  mem [num_sets];
    logic [index_w-1:0] wr_index;
    logic               wr_en;

    // Set being refilled sits in the low bits of the line address
    assign wr_index = rif.replace_addr[index_w-1:0];

    // Only the beat for this word position lands here
    assign wr_en = rif.read_valid && (rif.read_addr == bank_pos);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_sets; i++)
                mem[i] <= '0;
        end else if (wr_en) begin
            mem[wr_index] <= rif.read_rdata;
        end
    end

    assign rdata = mem[bank_index];   // Async read for zero wait hits

endmodule

//--- verilog/apb_cache_ctrl.sv
`timescale 1ns/100ps

module apb_cache_ctrl (
    input  logic                            clk,
    input  logic                            reset,

    // APB slave
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [cache_pkg::addr_w-1:0]    paddr,
    input  logic [cache_pkg::data_w-1:0]    pwdata,
    output logic [cache_pkg::data_w-1:0]    prdata,
    output logic                            pready,
    output logic                            pslverr,

    // Word banks
    input  logic [cache_pkg::words_per_line-1:0][cache_pkg::data_w-1:0] bank_rdata,
    output logic [cache_pkg::index_w-1:0]   bank_index,

    refill_if.ctrl                          rif
);
    import cache_pkg::*;

    ctrl_state_t            state;
    logic [tag_w-1:0]       tag_mem [num_sets];
    logic [num_sets-1:0]    valid_bits;
    logic                   seen_replace;   // Refill block has picked up the request
    logic [line_addr_w-1:0] req_line_addr;

    logic [tag_w-1:0]       addr_tag;
    logic [index_w-1:0]     addr_index;
    logic [offset_w-1:0]    addr_offset;
    logic                   hit;
    logic                   refill_done;
    logic [index_w-1:0]     req_index;

    // Split the APB address
    assign addr_tag    = paddr[tag_lsb +: tag_w];
    assign addr_index  = paddr[index_lsb +: index_w];
    assign addr_offset = paddr[offset_lsb +: offset_w];

    assign hit = valid_bits[addr_index] && (tag_mem[addr_index] == addr_tag);

    assign req_index = req_line_addr[index_w-1:0];

    // replace went high and has dropped again
    assign refill_done = seen_replace && !rif.replace;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= ctrl_idle;
            valid_bits   <= '0;
            seen_replace <= 1'b0;
        end else begin
            case (state)
                ctrl_idle: begin
                    seen_replace <= 1'b0;
                    if (psel && !penable)   // Setup phase
                        state <= ctrl_lookup;
                end
                ctrl_lookup: begin
                    if (!pwrite && !hit) begin
                        valid_bits[addr_index] <= 1'b0;   // Line is being replaced
                        state <= ctrl_refill_wait;
                    end else begin
                        state <= ctrl_idle;
                    end
                end
                ctrl_refill_wait: begin
                    if (rif.replace)
                        seen_replace <= 1'b1;
                    if (refill_done) begin
                        valid_bits[req_index] <= 1'b1;
                        state <= ctrl_respond;
                    end
                end
                default: begin
                    state <= ctrl_idle;
                end
            endcase
        end
    end

    // Tag and line address of the pending miss
    always_ff @(posedge clk) begin
        if (state == ctrl_lookup)
            req_line_addr <= paddr[addr_w-1:index_lsb];
        if (state == ctrl_refill_wait && refill_done)
            tag_mem[req_index] <= req_line_addr[line_addr_w-1:index_w];
    end

    // Held from the cycle after lookup until the fetch ends
    assign rif.replace_valid = (state == ctrl_refill_wait) && !refill_done;
    assign rif.replace_addr  = req_line_addr;

    assign bank_index = addr_index;
    assign prdata     = bank_rdata[addr_offset];

    // Writes are refused with an error
    assign pslverr = (state == ctrl_lookup) && pwrite;
    assign pready  = ((state == ctrl_lookup) && (pwrite || hit))
                     || (state == ctrl_respond);

    a_pready_in_access: assert property (
        @(posedge clk) disable iff (reset)
        pready |-> psel && penable
    );

endmodule

//--- verilog/apb_axi_cache.sv
`timescale 1ns/100ps

module apb_axi_cache (
    input  logic                            clk,
    input  logic                            reset,

    // APB3 slave
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [cache_pkg::addr_w-1:0]    paddr,
    input  logic [cache_pkg::data_w-1:0]    pwdata,
    output logic [cache_pkg::data_w-1:0]    prdata,
    output logic                            pready,
    output logic                            pslverr,

    // AXI4 read address
    output logic                            arvalid,
    input  logic                            arready,
    output logic [cache_pkg::addr_w-1:0]    araddr,
    output logic [7:0]                      arlen,
    output logic [2:0]                      arsize,
    output logic [1:0]                      arburst,
    output logic [3:0]                      arcache,
    output logic [axi_pkg::axi_id_w-1:0]    arid,

    // AXI4 read data
    input  logic                            rvalid,
    output logic                            rready,
    input  logic [cache_pkg::data_w-1:0]    rdata,
    input  logic [1:0]                      rresp,
    input  logic                            rlast
);
    import cache_pkg::*;

    logic [words_per_line-1:0][data_w-1:0] bank_rdata;
    logic [index_w-1:0]                    bank_index;

    refill_if rif ();

    apb_cache_ctrl i_apb_cache_ctrl (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .bank_rdata (bank_rdata),
        .bank_index (bank_index),
        .rif        (rif)
    );

    line_refill_axi i_line_refill_axi (
        .clk     (clk),
        .reset   (reset),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arcache (arcache),
        .arid    (arid),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rif     (rif)
    );

    // One bank per word position in the line
    for (genvar b = 0; b < words_per_line; b++) begin : g_bank
        line_word_bank #(
            .bank_pos (offset_w'(b))
        ) i_line_word_bank (
            .clk        (clk),
            .reset      (reset),
            .bank_index (bank_index),
            .rdata      (bank_rdata[b]),
            .rif        (rif)
        );
    end

endmodule

//--- dv/axi_mem_model.sv
`timescale 1ns/100ps

module axi_mem_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast
);

    integer      seed = 52;
    logic        busy;          // Burst accepted, beats still to send
    logic [31:0] burst_addr;
    int          beat;
    logic        bad_burst;     // This burst carries one SLVERR beat
    int          bad_beat;

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = 32'h0;
        rresp   = 2'b00;
        rlast   = 1'b0;
        busy    = 1'b0;
    end

    // Outputs change on the falling edge and the DUT samples them on the rising one
    always @(negedge clk) begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        if (reset) begin
            busy = 1'b0;
            beat = 0;
        end else if (!busy) begin
            // arvalid stays put until the next rising edge, so this accepts the address
            if (arvalid && (($random(seed) & 3) != 0)) begin
                arready    = 1'b1;
                busy       = 1'b1;
                burst_addr = araddr;
                beat       = 0;
                bad_burst  = (($random(seed) & 3) == 0);   // About one burst in four
                bad_beat   = $random(seed) & 3;
            end
        end else if (($random(seed) & 3) != 0) begin
            rvalid = 1'b1;
            rdata  = (burst_addr + 32'(4 * beat)) ^ 32'h5a5a_0000;
            rresp  = (bad_burst && beat == bad_beat) ? 2'b10 : 2'b00;   // SLVERR
            rlast  = (beat == 3);
            if (rready) begin
                if (beat == 3)
                    busy = 1'b0;
                beat++;
            end
        end
    end

endmodule

//--- dv/tb_apb_axi_cache.sv
`timescale 1ns/100ps

module tb_apb_axi_cache;

    localparam int half_period = 10;
    localparam int sample_delay = 5;       // Quarter period after the falling edge
    localparam int timeout_cycles = 200;
    localparam int num_transfers = 400;
    localparam logic [31:0] window_base = 32'h0001_0000;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic [3:0]  arcache;
    logic [axi_pkg::axi_id_w-1:0] arid;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rlast;

    integer      seed = 52;
    int          errors = 0;
    logic [31:0] ar_addrs[$];      // AR addresses of the current transfer
    bit          burst_errs[$];    // One entry per finished burst, set if a beat failed
    bit          burst_bad = 1'b0;
    logic [23:0] ref_tag[16];
    bit          ref_valid[16];

    apb_axi_cache i_apb_axi_cache (.*);

    axi_mem_model i_axi_mem_model (.*);

    always #half_period clk = ~clk;

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    // Handshakes complete on the rising edge
    always @(posedge clk) begin
        if (!reset && arvalid && arready) begin
            ar_addrs.push_back(araddr);
            if (araddr[3:0] != 4'h0 || arlen != 8'd3 || arsize != 3'd2
                    || arburst != 2'b01 || arcache != 4'b0011 || arid != '0) begin
                $display("Error at %0t: bad AR addr %h len %0d size %0d burst %0d",
                         $time, araddr, arlen, arsize, arburst);
                $display("  cache %b id %0d", arcache, arid);
                errors++;
            end
        end
        if (!reset && rvalid && rready) begin
            if (rresp != 2'b00)
                burst_bad = 1'b1;
            if (rlast) begin
                burst_errs.push_back(burst_bad);
                burst_bad = 1'b0;
            end
        end
    end

    task automatic check_quiet(input string when_txt);
        if ({arvalid, rready, pready} !== 3'b000) begin
            $display("Error at %0t: %s arvalid %b rready %b pready %b",
                     $time, when_txt, arvalid, rready, pready);
            errors++;
        end
    endtask

    // One APB transfer with setup and access cycles until pready
    task automatic apb_transfer(input logic is_write, input logic [31:0] addr,
                                output logic [31:0] rd_data, output logic err,
                                output int waits, output bit done);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = is_write;
        paddr   = addr;
        pwdata  = is_write ? $random(seed) : 32'h0;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        #sample_delay;
        while (pready !== 1'b1 && waits < timeout_cycles) begin
            @(negedge clk);
            #sample_delay;
            waits++;
        end
        done    = (pready === 1'b1);
        rd_data = prdata;
        err     = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // A miss fetches the line, repeating only after bursts that had an error
    task automatic check_refill(input logic [31:0] addr);
        logic [31:0] line_addr;
        line_addr = {addr[31:4], 4'h0};
        if (ar_addrs.size() == 0 || ar_addrs.size() != burst_errs.size()) begin
            $display("Error at %0t: miss at %h gave %0d AR and %0d bursts",
                     $time, addr, ar_addrs.size(), burst_errs.size());
            errors++;
        end else begin
            for (int i = 0; i < ar_addrs.size(); i++) begin
                if (ar_addrs[i] != line_addr
                        || burst_errs[i] != (i < ar_addrs.size() - 1)) begin
                    $display("Error at %0t: miss at %h, burst %0d addr %h error %b",
                             $time, addr, i, ar_addrs[i], burst_errs[i]);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] rd_data;
        logic        err;
        logic        is_write;
        logic        exp_hit;
        int          waits;
        bit          done;
        int          count;

        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 32'h0;
        pwdata  = 32'h0;
        repeat (3) begin
            @(negedge clk);
            check_quiet("during reset");
        end
        reset = 1'b0;
        @(negedge clk);
        check_quiet("after reset");

        count = 0;
        done  = 1'b1;
        while (done && count < num_transfers) begin
            is_write = (($random(seed) & 7) == 0);
            addr     = window_base + ($random(seed) & 32'h1fc);   // 512 byte window
            exp_hit  = ref_valid[addr[7:4]] && (ref_tag[addr[7:4]] == addr[31:8]);
            ar_addrs.delete();
            burst_errs.delete();
            apb_transfer(is_write, addr, rd_data, err, waits, done);
            if (!done) begin
                $display("APB transfer to %h got no pready within %0d cycles",
                         addr, timeout_cycles);
                errors++;
            end else if (is_write) begin
                if (!err || waits != 0 || ar_addrs.size() != 0) begin
                    $display("Error at %0t: write to %h pslverr %b waits %0d AR %0d",
                             $time, addr, err, waits, ar_addrs.size());
                    errors++;
                end
            end else begin
                if (rd_data !== mem_word(addr) || err !== 1'b0) begin
                    $display("Error at %0t: read %h returned %h pslverr %b, expected %h",
                             $time, addr, rd_data, err, mem_word(addr));
                    errors++;
                end
                if (exp_hit) begin
                    if (waits != 0 || ar_addrs.size() != 0) begin
                        $display("Error at %0t: hit at %h took %0d waits and %0d AR",
                                 $time, addr, waits, ar_addrs.size());
                        errors++;
                    end
                end else begin
                    check_refill(addr);
                    ref_valid[addr[7:4]] = 1'b1;
                    ref_tag[addr[7:4]]   = addr[31:8];
                end
            end
            count++;
        end

        $display("%0d APB transfers checked, %0d errors", count, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- build.f
verilog/cache_pkg.sv
verilog/axi_pkg.sv
verilog/refill_if.sv
verilog/line_refill_axi.sv
verilog/line_word_bank.sv
verilog/apb_cache_ctrl.sv
verilog/apb_axi_cache.sv
dv/axi_mem_model.sv
dv/tb_apb_axi_cache.sv

//--- run_sim.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_apb_axi_cache -f build.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log && exit 0 || exit 1
